/* common/ffu_pkg.sv */
//////////////////////////////////////////////////
// ffu package
// widths, thread count and FSR layouts shared by
// the floating-point front-end datapath
//////////////////////////////////////////////////

package ffu_pkg;

   localparam int num_threads = 4;
   localparam int data_w      = 64;      // operand word
   localparam int half_w      = 32;      // single-precision word
   localparam int fsr_w       = 28;      // compacted FSR
   localparam int gsr_w       = 37;      // mask[36:5], scale[4:0]
   localparam int exc_w       = 10;      // aexc + cexc
   localparam int fcc_w       = 8;       // fcc3..fcc0
   localparam int ftt_w       = 3;
   localparam int tem_w       = 5;       // also aexc, cexc width
   localparam int rnd_w       = 2;

   //////////////////////////////////////////////////
   // FSR as it sits in a 64-bit memory word
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [25:0]       rsvd_hi;        // 63:38
      logic [fcc_w-3:0]  fcc_hi;         // fcc3,fcc2,fcc1
      logic [rnd_w-1:0]  rnd;
      logic [1:0]        rsvd_29_28;
      logic [tem_w-1:0]  tem;
      logic [5:0]        ns_ver;         // ns, rsvd, ver
      logic [ftt_w-1:0]  ftt;
      logic [1:0]        qne_rsvd;
      logic [1:0]        fcc0;
      logic [tem_w-1:0]  aexc;
      logic [tem_w-1:0]  cexc;
   } fsr_fields_t;

   // one load word, seen as data or as an FSR image
   typedef union packed {
      logic [data_w-1:0] raw;
      fsr_fields_t       fld;
   } fsr_image_u;

   //////////////////////////////////////////////////
   // compacted FSR, only the bits that can be nonzero
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [fcc_w-3:0]  fcc_hi;
      logic [rnd_w-1:0]  rnd;
      logic [tem_w-1:0]  tem;
      logic [ftt_w-1:0]  ftt;
      logic [1:0]        fcc0;
      logic [tem_w-1:0]  aexc;
      logic [tem_w-1:0]  cexc;
   } fsr_t;

endpackage

/* ffu_operand_path/ffu_operand_path.sv */
//////////////////////////////////////////////////
// ffu operand path
// input flops, FRF alignment for singles, LSU/FPU
// flip, rs1/rs2/write registers and the store mux
//////////////////////////////////////////////////

module ffu_operand_path (
   input  logic                       rclk,
   input  logic                       rst,
   input  logic [ffu_pkg::data_w-1:0] frf_rd_data,
   input  logic [ffu_pkg::data_w-1:0] cpx_fpu_data,
   input  logic [ffu_pkg::data_w-1:0] lsu_ld_data,
   input  logic [ffu_pkg::data_w-1:0] vis_rd_data,
   input  logic [1:0]                 sign,            // after fabs/fneg
   input  logic                       noshift_frf,
   input  logic                       shift_frf_right,
   input  logic                       shift_frf_left,
   input  logic                       zero_low32_frf,
   input  logic                       noflip_lsu,
   input  logic                       flip_lsu,
   input  logic                       noflip_fpu,
   input  logic                       flip_fpu,
   input  logic                       rs2_sel_frf,
   input  logic                       rs2_sel_vis,
   input  logic                       rs2_sel_fpu_lsu,
   input  logic                       new_rs1,
   input  logic                       out_sel_rs1,
   input  logic                       out_sel_rs2,
   input  logic                       out_sel_frf,
   input  logic                       out_sel_fsr,
   input  ffu_pkg::fsr_t              current_fsr,
   output ffu_pkg::fsr_image_u        ld_word,
   output logic [ffu_pkg::data_w-1:0] frf_wr_data,
   output logic [ffu_pkg::data_w-1:0] lsu_store_data,
   output logic [ffu_pkg::data_w-1:0] vis_rs1_data,
   output logic [ffu_pkg::data_w-1:0] vis_rs2_data,
   output logic [1:0]                 rs2_sign
);
   import ffu_pkg::*;

   logic [data_w-1:0] cpx_q;
   logic [data_w-1:0] shifted_frf;
   logic [data_w-1:0] new_frf;
   logic [data_w-1:0] rs2_changed;
   logic [data_w-1:0] lsu_fpu_data;
   logic [data_w-1:0] rs2_q;
   logic [data_w-1:0] rs1_q;
   logic [data_w-1:0] wr_q;
   fsr_image_u        fsr_img;

   //////////////////////////////////////////////////
   // input flops
   //////////////////////////////////////////////////
   always_ff @(posedge rclk) begin
      cpx_q <= cpx_fpu_data;
   end

   // flopped load word, ld_fcc reads it directly
   always_ff @(posedge rclk) begin
      if (rst) begin
         ld_word.raw <= '0;
      end else begin
         ld_word.raw <= lsu_ld_data;
      end
   end

   //////////////////////////////////////////////////
   // FRF alignment
   //////////////////////////////////////////////////
   // singles may sit in either half of a 64-bit read, move them
   // to where the consumer expects them
   always_comb begin
      shifted_frf = (frf_rd_data & {data_w{noshift_frf}})
         | ({{half_w{1'b0}}, frf_rd_data[data_w-1:half_w]} & {data_w{shift_frf_right}})
         | ({frf_rd_data[half_w-1:0], {half_w{1'b0}}} & {data_w{shift_frf_left}});
   end

   assign new_frf = {shifted_frf[data_w-1:half_w],
                     shifted_frf[half_w-1:0] & {half_w{~zero_low32_frf}}};

   // original signs to control, replacement signs into rs2
   assign rs2_sign    = {new_frf[data_w-1], new_frf[half_w-1]};
   assign rs2_changed = {sign[1], new_frf[data_w-2:half_w],
                         sign[0], new_frf[half_w-2:0]};

   // return data from lsu or fpu, optionally word flipped
   always_comb begin
      lsu_fpu_data = (ld_word.raw & {data_w{noflip_lsu}})
         | ({ld_word.raw[half_w-1:0], {half_w{1'b0}}} & {data_w{flip_lsu}})
         | (cpx_q & {data_w{noflip_fpu}})
         | ({{half_w{1'b0}}, cpx_q[data_w-1:half_w]} & {data_w{flip_fpu}});
   end

   //////////////////////////////////////////////////
   // operand registers
   //////////////////////////////////////////////////
   always_ff @(posedge rclk) begin
      if (rs2_sel_frf) begin
         rs2_q <= rs2_changed;
      end else if (rs2_sel_vis) begin
         rs2_q <= vis_rd_data;
      end else if (rs2_sel_fpu_lsu) begin
         rs2_q <= lsu_fpu_data;
      end
   end

   always_ff @(posedge rclk) begin
      if (new_rs1) begin
         rs1_q <= new_frf;
      end
      wr_q <= rs2_q;        // block loads are pipelined
   end

   assign vis_rs2_data = rs2_q;
   assign vis_rs1_data = rs1_q;
   assign frf_wr_data  = wr_q;

   //////////////////////////////////////////////////
   // store data to lsu
   //////////////////////////////////////////////////
   // expand compacted FSR, reserved bits read as zero
   always_comb begin
      fsr_img             = '0;
      fsr_img.fld.fcc_hi  = current_fsr.fcc_hi;
      fsr_img.fld.rnd     = current_fsr.rnd;
      fsr_img.fld.tem     = current_fsr.tem;
      fsr_img.fld.ftt     = current_fsr.ftt;
      fsr_img.fld.fcc0    = current_fsr.fcc0;
      fsr_img.fld.aexc    = current_fsr.aexc;
      fsr_img.fld.cexc    = current_fsr.cexc;
   end

   always_comb begin
      lsu_store_data = (rs2_q & {data_w{out_sel_rs2}})
         | (rs1_q & {data_w{out_sel_rs1}})
         | (shifted_frf & {data_w{out_sel_frf}})       // not low-zeroed
         | (fsr_img.raw & {data_w{out_sel_fsr}});
   end

endmodule

/* verilog/ffu_fsr_file.sv */
//////////////////////////////////////////////////
// ffu FSR file
// one compacted FSR per thread, updated by ldfsr
// or by FPU results, current thread fields out
//////////////////////////////////////////////////

module ffu_fsr_file (
   input  logic                            rclk,
   input  logic                            rst,
   input  ffu_pkg::fsr_image_u             ld_word,
   input  logic [ffu_pkg::fcc_w-1:0]       fcc_w2,
   input  logic [ffu_pkg::ftt_w-1:0]       ftt_w2,
   input  logic [ffu_pkg::exc_w-1:0]       exc_w2,
   input  logic [ffu_pkg::num_threads-1:0] fsr_sel_ld,
   input  logic [ffu_pkg::num_threads-1:0] fsr_sel_fpu,
   input  logic [ffu_pkg::num_threads-1:0] fp_thr,
   output ffu_pkg::fsr_t                   current_fsr,
   output logic [ffu_pkg::fcc_w-1:0]       fsr_fcc,
   output logic [ffu_pkg::rnd_w-1:0]       fsr_rnd,
   output logic [ffu_pkg::tem_w-1:0]       fsr_tem,
   output logic [ffu_pkg::tem_w-1:0]       fsr_aexc,
   output logic [ffu_pkg::tem_w-1:0]       fsr_cexc,
   output logic [ffu_pkg::fcc_w-1:0]       ld_fcc
);
   import ffu_pkg::*;

   fsr_t             fsr_q [num_threads];
   logic [fsr_w-1:0] cur_raw;

   //////////////////////////////////////////////////
   // per-thread update
   //////////////////////////////////////////////////
   // load beats fpu, neither set means hold
   always_ff @(posedge rclk) begin
      if (rst) begin
         for (int t = 0; t < num_threads; t++) begin
            fsr_q[t] <= '0;
         end
      end else begin
         for (int t = 0; t < num_threads; t++) begin
            if (fsr_sel_ld[t]) begin
               // ftt survives a load
               fsr_q[t].fcc_hi <= fcc_w2[fcc_w-1:2];
               fsr_q[t].rnd    <= ld_word.fld.rnd;
               fsr_q[t].tem    <= ld_word.fld.tem;
               fsr_q[t].fcc0   <= ld_word.fld.fcc0;
               fsr_q[t].aexc   <= ld_word.fld.aexc;
               fsr_q[t].cexc   <= ld_word.fld.cexc;
            end else if (fsr_sel_fpu[t]) begin
               // rnd and tem kept
               fsr_q[t].fcc_hi <= fcc_w2[fcc_w-1:2];
               fsr_q[t].ftt    <= ftt_w2;
               fsr_q[t].fcc0   <= fcc_w2[1:0];
               {fsr_q[t].aexc, fsr_q[t].cexc} <= exc_w2;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // current thread
   //////////////////////////////////////////////////
   always_comb begin
      cur_raw = '0;
      for (int t = 0; t < num_threads; t++) begin
         cur_raw = cur_raw | (fsr_q[t] & {fsr_w{fp_thr[t]}});   // one-hot
      end
   end

   assign current_fsr = fsr_t'(cur_raw);

   assign fsr_fcc  = {current_fsr.fcc_hi, current_fsr.fcc0};
   assign fsr_rnd  = current_fsr.rnd;
   assign fsr_tem  = current_fsr.tem;
   assign fsr_aexc = current_fsr.aexc;
   assign fsr_cexc = current_fsr.cexc;

   // early look at the loaded condition codes
   assign ld_fcc = {ld_word.fld.fcc_hi, ld_word.fld.fcc0};

endmodule

/* verilog/ffu_gsr_file.sv */
//////////////////////////////////////////////////
// ffu GSR file
// one GSR per thread, written by wrgsr, read out
// for the execute-stage thread
//////////////////////////////////////////////////

module ffu_gsr_file (
   input  logic                            rclk,
   input  logic                            rst,
   input  logic [ffu_pkg::gsr_w-1:0]       wsr_data_w2,
   input  logic [ffu_pkg::num_threads-1:0] gsr_wsr_w2,
   input  logic [ffu_pkg::num_threads-1:0] thr_e,
   output logic [31:0]                     gsr_mask_e,
   output logic [4:0]                      gsr_scale_e
);
   import ffu_pkg::*;

   logic [gsr_w-1:0] gsr_q [num_threads];
   logic [gsr_w-1:0] gsr_e;

   // align and rnd fields live in control, only mask and scale here
   always_ff @(posedge rclk) begin
      if (rst) begin
         for (int t = 0; t < num_threads; t++) begin
            gsr_q[t] <= '0;
         end
      end else begin
         for (int t = 0; t < num_threads; t++) begin
            if (gsr_wsr_w2[t]) begin
               gsr_q[t] <= wsr_data_w2;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // execute-stage select
   //////////////////////////////////////////////////
   always_comb begin
      gsr_e = '0;
      for (int t = 0; t < num_threads; t++) begin
         gsr_e = gsr_e | (gsr_q[t] & {gsr_w{thr_e[t]}});   // one-hot thr_e
      end
   end

   assign gsr_mask_e  = gsr_e[gsr_w-1:5];
   assign gsr_scale_e = gsr_e[4:0];

endmodule

/* verilog/ffu_dp.sv */
//////////////////////////////////////////////////
// ffu datapath top
// operand path plus the per-thread FSR and GSR
// state files of the floating-point front end
//////////////////////////////////////////////////

module ffu_dp (
   input  logic                            rclk,
   input  logic                            rst,
   // data
   input  logic [ffu_pkg::data_w-1:0]      frf_rd_data,
   input  logic [ffu_pkg::data_w-1:0]      cpx_fpu_data,
   input  logic [ffu_pkg::data_w-1:0]      lsu_ld_data,
   input  logic [ffu_pkg::data_w-1:0]      vis_rd_data,
   // control words
   input  logic [ffu_pkg::gsr_w-1:0]       wsr_data_w2,
   input  logic [1:0]                      sign,
   input  logic [ffu_pkg::exc_w-1:0]       exc_w2,
   input  logic [ffu_pkg::fcc_w-1:0]       fcc_w2,
   input  logic [ffu_pkg::ftt_w-1:0]       ftt_w2,
   // alignment and flip selects
   input  logic                            noshift_frf,
   input  logic                            shift_frf_right,
   input  logic                            shift_frf_left,
   input  logic                            zero_low32_frf,
   input  logic                            noflip_lsu,
   input  logic                            flip_lsu,
   input  logic                            noflip_fpu,
   input  logic                            flip_fpu,
   // operand selects
   input  logic                            rs2_sel_frf,
   input  logic                            rs2_sel_vis,
   input  logic                            rs2_sel_fpu_lsu,
   input  logic                            new_rs1,
   // store selects
   input  logic                            out_sel_rs1,
   input  logic                            out_sel_rs2,
   input  logic                            out_sel_frf,
   input  logic                            out_sel_fsr,
   // per-thread strobes
   input  logic [ffu_pkg::num_threads-1:0] fsr_sel_ld,
   input  logic [ffu_pkg::num_threads-1:0] fsr_sel_fpu,
   input  logic [ffu_pkg::num_threads-1:0] fp_thr,
   input  logic [ffu_pkg::num_threads-1:0] gsr_wsr_w2,
   input  logic [ffu_pkg::num_threads-1:0] thr_e,
   // data out
   output logic [ffu_pkg::data_w-1:0]      frf_wr_data,
   output logic [ffu_pkg::data_w-1:0]      lsu_store_data,
   output logic [ffu_pkg::data_w-1:0]      vis_rs1_data,
   output logic [ffu_pkg::data_w-1:0]      vis_rs2_data,
   output logic [1:0]                      rs2_sign,
   // FSR fields
   output logic [ffu_pkg::fcc_w-1:0]       fsr_fcc,
   output logic [ffu_pkg::rnd_w-1:0]       fsr_rnd,
   output logic [ffu_pkg::tem_w-1:0]       fsr_tem,
   output logic [ffu_pkg::tem_w-1:0]       fsr_aexc,
   output logic [ffu_pkg::tem_w-1:0]       fsr_cexc,
   output logic [ffu_pkg::fcc_w-1:0]       ld_fcc,
   // GSR fields
   output logic [31:0]                     gsr_mask_e,
   output logic [4:0]                      gsr_scale_e
);
   import ffu_pkg::*;

   fsr_image_u ld_word;      // flopped lsu word
   fsr_t       current_fsr;  // fp_thr thread

   ffu_operand_path i_operand_path (
      .rclk            (rclk),
      .rst             (rst),
      .frf_rd_data     (frf_rd_data),
      .cpx_fpu_data    (cpx_fpu_data),
      .lsu_ld_data     (lsu_ld_data),
      .vis_rd_data     (vis_rd_data),
      .sign            (sign),
      .noshift_frf     (noshift_frf),
      .shift_frf_right (shift_frf_right),
      .shift_frf_left  (shift_frf_left),
      .zero_low32_frf  (zero_low32_frf),
      .noflip_lsu      (noflip_lsu),
      .flip_lsu        (flip_lsu),
      .noflip_fpu      (noflip_fpu),
      .flip_fpu        (flip_fpu),
      .rs2_sel_frf     (rs2_sel_frf),
      .rs2_sel_vis     (rs2_sel_vis),
      .rs2_sel_fpu_lsu (rs2_sel_fpu_lsu),
      .new_rs1         (new_rs1),
      .out_sel_rs1     (out_sel_rs1),
      .out_sel_rs2     (out_sel_rs2),
      .out_sel_frf     (out_sel_frf),
      .out_sel_fsr     (out_sel_fsr),
      .current_fsr     (current_fsr),
      .ld_word         (ld_word),
      .frf_wr_data     (frf_wr_data),
      .lsu_store_data  (lsu_store_data),
      .vis_rs1_data    (vis_rs1_data),
      .vis_rs2_data    (vis_rs2_data),
      .rs2_sign        (rs2_sign)
   );

   ffu_fsr_file i_fsr_file (
      .rclk        (rclk),
      .rst         (rst),
      .ld_word     (ld_word),
      .fcc_w2      (fcc_w2),
      .ftt_w2      (ftt_w2),
      .exc_w2      (exc_w2),
      .fsr_sel_ld  (fsr_sel_ld),
      .fsr_sel_fpu (fsr_sel_fpu),
      .fp_thr      (fp_thr),
      .current_fsr (current_fsr),
      .fsr_fcc     (fsr_fcc),
      .fsr_rnd     (fsr_rnd),
      .fsr_tem     (fsr_tem),
      .fsr_aexc    (fsr_aexc),
      .fsr_cexc    (fsr_cexc),
      .ld_fcc      (ld_fcc)
   );

   ffu_gsr_file i_gsr_file (
      .rclk        (rclk),
      .rst         (rst),
      .wsr_data_w2 (wsr_data_w2),
      .gsr_wsr_w2  (gsr_wsr_w2),
      .thr_e       (thr_e),
      .gsr_mask_e  (gsr_mask_e),
      .gsr_scale_e (gsr_scale_e)
   );

endmodule

/* verif/ffu_dp_checker.sv */
//////////////////////////////////////////////////
// ffu datapath checker
// reference model of operands, FSR and GSR files,
// compared against the top-level ports
//////////////////////////////////////////////////

module ffu_dp_checker (
   input logic                            rclk,
   input logic                            rst,
   input logic [ffu_pkg::data_w-1:0]      frf_rd_data,
   input logic [ffu_pkg::data_w-1:0]      cpx_fpu_data,
   input logic [ffu_pkg::data_w-1:0]      lsu_ld_data,
   input logic [ffu_pkg::data_w-1:0]      vis_rd_data,
   input logic [ffu_pkg::gsr_w-1:0]       wsr_data_w2,
   input logic [1:0]                      sign,
   input logic [ffu_pkg::exc_w-1:0]       exc_w2,
   input logic [ffu_pkg::fcc_w-1:0]       fcc_w2,
   input logic [ffu_pkg::ftt_w-1:0]       ftt_w2,
   input logic                            noshift_frf,
   input logic                            shift_frf_right,
   input logic                            shift_frf_left,
   input logic                            zero_low32_frf,
   input logic                            noflip_lsu,
   input logic                            flip_lsu,
   input logic                            noflip_fpu,
   input logic                            flip_fpu,
   input logic                            rs2_sel_frf,
   input logic                            rs2_sel_vis,
   input logic                            rs2_sel_fpu_lsu,
   input logic                            new_rs1,
   input logic                            out_sel_rs1,
   input logic                            out_sel_rs2,
   input logic                            out_sel_frf,
   input logic                            out_sel_fsr,
   input logic [ffu_pkg::num_threads-1:0] fsr_sel_ld,
   input logic [ffu_pkg::num_threads-1:0] fsr_sel_fpu,
   input logic [ffu_pkg::num_threads-1:0] fp_thr,
   input logic [ffu_pkg::num_threads-1:0] gsr_wsr_w2,
   input logic [ffu_pkg::num_threads-1:0] thr_e,
   input logic [ffu_pkg::data_w-1:0]      frf_wr_data,
   input logic [ffu_pkg::data_w-1:0]      lsu_store_data,
   input logic [ffu_pkg::data_w-1:0]      vis_rs1_data,
   input logic [ffu_pkg::data_w-1:0]      vis_rs2_data,
   input logic [1:0]                      rs2_sign,
   input logic [ffu_pkg::fcc_w-1:0]       fsr_fcc,
   input logic [ffu_pkg::rnd_w-1:0]       fsr_rnd,
   input logic [ffu_pkg::tem_w-1:0]       fsr_tem,
   input logic [ffu_pkg::tem_w-1:0]       fsr_aexc,
   input logic [ffu_pkg::tem_w-1:0]       fsr_cexc,
   input logic [ffu_pkg::fcc_w-1:0]       ld_fcc,
   input logic [31:0]                     gsr_mask_e,
   input logic [4:0]                      gsr_scale_e
);
   import ffu_pkg::*;

   logic [63:0] ld_m, cpx_m, frf_shift, frf_al, ret_data;
   logic [63:0] exp_rs2, exp_rs1, exp_wr, exp_store, img;
   logic [27:0] fsr_m [num_threads];   // fcc, rnd, tem, ftt, aexc, cexc
   logic [27:0] cur_fsr;
   logic [36:0] gsr_m [num_threads];
   logic [36:0] cur_gsr;
   int          err_count = 0;

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////
   always_comb begin
      frf_shift = noshift_frf ? frf_rd_data
         : shift_frf_right ? {32'h0, frf_rd_data[63:32]}
         : shift_frf_left ? {frf_rd_data[31:0], 32'h0} : 64'h0;
      frf_al = {frf_shift[63:32], zero_low32_frf ? 32'h0 : frf_shift[31:0]};
      ret_data = noflip_lsu ? ld_m : flip_lsu ? {ld_m[31:0], 32'h0}
         : noflip_fpu ? cpx_m : flip_fpu ? {32'h0, cpx_m[63:32]} : 64'h0;
      cur_fsr = '0;
      cur_gsr = '0;
      for (int t = 0; t < num_threads; t++) begin
         if (fp_thr[t]) cur_fsr = fsr_m[t];
         if (thr_e[t]) cur_gsr = gsr_m[t];
      end
      img = '0;                                        // reserved bits zero
      img[37:30] = {cur_fsr[27:22], cur_fsr[19:18]};   // fcc3..1, rnd
      img[27:23] = cur_fsr[17:13];
      img[16:14] = cur_fsr[12:10];
      img[11:0]  = {cur_fsr[21:20], cur_fsr[9:0]};     // fcc0, aexc, cexc
      exp_store = out_sel_rs2 ? exp_rs2 : out_sel_rs1 ? exp_rs1
         : out_sel_frf ? frf_shift : out_sel_fsr ? img : 64'h0;
   end

   always @(posedge rclk) begin
      ld_m  <= rst ? 64'h0 : lsu_ld_data;
      cpx_m <= cpx_fpu_data;
      if (rs2_sel_frf) exp_rs2 <= {sign[1], frf_al[62:32], sign[0], frf_al[30:0]};
      else if (rs2_sel_vis) exp_rs2 <= vis_rd_data;
      else if (rs2_sel_fpu_lsu) exp_rs2 <= ret_data;
      if (new_rs1) exp_rs1 <= frf_al;
      exp_wr <= exp_rs2;
      for (int t = 0; t < num_threads; t++) begin
         if (rst) begin
            fsr_m[t] <= '0;
            gsr_m[t] <= '0;
         end else begin
            if (fsr_sel_ld[t]) begin
               fsr_m[t] <= {fcc_w2[7:2], ld_m[11:10], ld_m[31:30], ld_m[27:23],
                            fsr_m[t][12:10], ld_m[9:0]};
            end else if (fsr_sel_fpu[t]) begin
               fsr_m[t] <= {fcc_w2, fsr_m[t][19:13], ftt_w2, exc_w2};
            end
            if (gsr_wsr_w2[t]) gsr_m[t] <= wsr_data_w2;
         end
      end
   end

   //////////////////////////////////////////////////
   // assertions
   //////////////////////////////////////////////////
   a_rs2: assert property (@(posedge rclk) disable iff (rst) vis_rs2_data == exp_rs2)
      else begin
         err_count++;
         $error("error t=%0t vis_rs2_data exp=%h got=%h",
            $time, $sampled(exp_rs2), $sampled(vis_rs2_data));
      end
   a_rs1: assert property (@(posedge rclk) disable iff (rst) vis_rs1_data == exp_rs1)
      else begin
         err_count++;
         $error("error t=%0t vis_rs1_data exp=%h got=%h",
            $time, $sampled(exp_rs1), $sampled(vis_rs1_data));
      end
   a_wr: assert property (@(posedge rclk) disable iff (rst) frf_wr_data == exp_wr)
      else begin
         err_count++;
         $error("error t=%0t frf_wr_data exp=%h got=%h",
            $time, $sampled(exp_wr), $sampled(frf_wr_data));
      end
   a_store: assert property (@(posedge rclk) disable iff (rst) lsu_store_data == exp_store)
      else begin
         err_count++;
         $error("error t=%0t lsu_store_data exp=%h got=%h",
            $time, $sampled(exp_store), $sampled(lsu_store_data));
      end
   a_sign: assert property (@(posedge rclk) rs2_sign == {frf_al[63], frf_al[31]})
      else begin
         err_count++;
         $error("error t=%0t rs2_sign exp=%h got=%h",
            $time, $sampled({frf_al[63], frf_al[31]}), $sampled(rs2_sign));
      end
   a_fsr: assert property (@(posedge rclk) disable iff (rst)
      {fsr_fcc, fsr_rnd, fsr_tem, fsr_aexc, fsr_cexc} == {cur_fsr[27:13], cur_fsr[9:0]})
      else begin
         err_count++;
         $error("error t=%0t fsr fields exp=%h got=%h", $time,
            $sampled({cur_fsr[27:13], cur_fsr[9:0]}),
            $sampled({fsr_fcc, fsr_rnd, fsr_tem, fsr_aexc, fsr_cexc}));
      end
   a_ld_fcc: assert property (@(posedge rclk) disable iff (rst)
      ld_fcc == {ld_m[37:32], ld_m[11:10]})
      else begin
         err_count++;
         $error("error t=%0t ld_fcc exp=%h got=%h", $time,
            $sampled({ld_m[37:32], ld_m[11:10]}), $sampled(ld_fcc));
      end
   a_gsr: assert property (@(posedge rclk) {gsr_mask_e, gsr_scale_e} == cur_gsr)
      else begin
         err_count++;
         $error("error t=%0t gsr_mask_e/gsr_scale_e exp=%h got=%h",
            $time, $sampled(cur_gsr), $sampled({gsr_mask_e, gsr_scale_e}));
      end

endmodule

bind ffu_dp ffu_dp_checker i_checker (.*);

/* verif/ffu_dp_tb.sv */
//////////////////////////////////////////////////
// ffu datapath testbench
// directed and random stimulus, checking is done
// by the bound assertion checker
//////////////////////////////////////////////////

module ffu_dp_tb;
   import ffu_pkg::*;

   logic rclk, rst;
   logic [63:0] frf_rd_data, cpx_fpu_data, lsu_ld_data, vis_rd_data;
   logic [36:0] wsr_data_w2;
   logic [1:0]  sign, rs2_sign;
   logic [9:0]  exc_w2;
   logic [7:0]  fcc_w2, fsr_fcc, ld_fcc;
   logic [2:0]  ftt_w2;
   logic noshift_frf, shift_frf_right, shift_frf_left, zero_low32_frf;
   logic noflip_lsu, flip_lsu, noflip_fpu, flip_fpu;
   logic rs2_sel_frf, rs2_sel_vis, rs2_sel_fpu_lsu, new_rs1;
   logic out_sel_rs1, out_sel_rs2, out_sel_frf, out_sel_fsr;
   logic [3:0]  fsr_sel_ld, fsr_sel_fpu, fp_thr, gsr_wsr_w2, thr_e;
   logic [63:0] frf_wr_data, lsu_store_data, vis_rs1_data, vis_rs2_data;
   logic [1:0]  fsr_rnd;
   logic [4:0]  fsr_tem, fsr_aexc, fsr_cexc, gsr_scale_e;
   logic [31:0] gsr_mask_e;
   int seed = 4756;
   int cycles = 0;
   int fails_seen = 0;
   int tests_run = 0;

   ffu_dp i_ffu_dp (.*);

   initial begin
      rclk = 0;
      forever #5 rclk = ~rclk;
   end

   // about twice the length of all tests
   always @(posedge rclk) begin
      cycles <= cycles + 1;
      if (cycles >= 300) begin
         $display("run stopped, cycle limit reached before the tests ended");
         $display("Regression failed");
         $finish;
      end
   end

   function automatic int pick(int n);
      pick = ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   // new data on every data and control word input
   task automatic random_data();
      frf_rd_data  <= {$random(seed), $random(seed)};
      cpx_fpu_data <= {$random(seed), $random(seed)};
      lsu_ld_data  <= {$random(seed), $random(seed)};
      vis_rd_data  <= {$random(seed), $random(seed)};
      wsr_data_w2  <= 37'({$random(seed), $random(seed)});
      {sign, exc_w2, fcc_w2, ftt_w2} <= 23'($random(seed));
   endtask

   // one random one-hot choice per select group
   task automatic random_selects(bit use_fsr_out);
      int s, f, r, o;
      s = pick(3);
      f = pick(4);
      r = pick(4);
      o = pick(use_fsr_out ? 5 : 4);
      {noshift_frf, shift_frf_right, shift_frf_left} <= 3'b100 >> s;
      zero_low32_frf <= (pick(2) == 1);
      {noflip_lsu, flip_lsu, noflip_fpu, flip_fpu} <= 4'b1000 >> f;
      {rs2_sel_frf, rs2_sel_vis, rs2_sel_fpu_lsu} <= 3'(4'b1000 >> r);   // r = 0 holds
      new_rs1 <= (pick(2) == 1);
      {out_sel_rs2, out_sel_rs1, out_sel_frf, out_sel_fsr} <= 4'(5'b10000 >> o);
      fp_thr <= 4'b0001 << pick(4);
      thr_e  <= 4'b0001 << pick(4);
   endtask

   task automatic end_test(string name);
      int now;
      now = i_ffu_dp.i_checker.err_count;
      $display("test %s finished, %0d failures", name, now - fails_seen);
      fails_seen = now;
      tests_run++;
   endtask

   initial begin
      {frf_rd_data, cpx_fpu_data, lsu_ld_data, vis_rd_data} = '0;
      {wsr_data_w2, sign, exc_w2, fcc_w2, ftt_w2} = '0;
      {shift_frf_right, shift_frf_left, zero_low32_frf} = '0;
      {noflip_lsu, flip_lsu, noflip_fpu, flip_fpu} = '0;
      {rs2_sel_frf, rs2_sel_fpu_lsu, out_sel_rs1, out_sel_rs2} = '0;
      {out_sel_frf, out_sel_fsr} = '0;
      {fsr_sel_ld, fsr_sel_fpu, gsr_wsr_w2, fp_thr, thr_e} = '0;
      noshift_frf = 1;
      rs2_sel_vis = 1;       // known operands before checks start
      new_rs1     = 1;
      rst         = 1;
      repeat (4) @(posedge rclk);
      rst <= 0;

      // reset values on every thread
      for (int t = 0; t < num_threads; t++) begin
         @(posedge rclk);
         fp_thr <= 4'b0001 << t;
         thr_e  <= 4'b0001 << t;
         {out_sel_rs2, out_sel_rs1, out_sel_frf, out_sel_fsr} <= 4'b0001;
      end
      @(posedge rclk);
      end_test("reset");

      // FSR load one cycle after the LSU word
      for (int i = 0; i < 12; i++) begin
         @(posedge rclk);
         random_data();
         random_selects(1);
         fsr_sel_ld  <= 4'b0001 << (i % 4);
         fsr_sel_fpu <= '0;
         fp_thr      <= 4'b0001 << (i % 4);
      end
      @(posedge rclk);
      fsr_sel_ld <= '0;
      end_test("fsr load");

      // FPU update, last pass also raises a load on the same thread
      for (int i = 0; i < 12; i++) begin
         @(posedge rclk);
         random_data();
         random_selects(1);
         fsr_sel_fpu <= 4'b0001 << (i % 4);
         fsr_sel_ld  <= (i == 11) ? 4'b0001 << (i % 4) : 4'b0000;
      end
      @(posedge rclk);
      {fsr_sel_fpu, fsr_sel_ld} <= '0;
      end_test("fsr fpu");

      for (int i = 0; i < 12; i++) begin
         @(posedge rclk);
         random_data();
         random_selects(1);
         gsr_wsr_w2 <= 4'b0001 << pick(4);
      end
      @(posedge rclk);
      gsr_wsr_w2 <= '0;
      end_test("gsr");

      for (int i = 0; i < 60; i++) begin
         @(posedge rclk);
         random_data();
         random_selects(0);
      end
      end_test("operands");

      for (int i = 0; i < 40; i++) begin
         @(posedge rclk);
         random_data();
         random_selects(1);
         fsr_sel_ld <= (pick(4) == 0) ? 4'b0001 << pick(4) : 4'b0000;
      end
      @(posedge rclk);
      fsr_sel_ld <= '0;
      repeat (2) @(posedge rclk);
      end_test("store mux");

      $display("%0d tests run, %0d assertion failures", tests_run, fails_seen);
      if (fails_seen == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* ffu_dp.f */
common/ffu_pkg.sv
ffu_operand_path/ffu_operand_path.sv
verilog/ffu_fsr_file.sv
verilog/ffu_gsr_file.sv
verilog/ffu_dp.sv
verif/ffu_dp_checker.sv
verif/ffu_dp_tb.sv

/* Makefile */
# Verilator build for the ffu datapath

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        := ffu_dp_tb
RTL_TOP    := ffu_dp
FILELIST   := ffu_dp.f
OBJ_DIR    := obj_dir
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from grep, output still goes to the terminal
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
